// ==== source/core_pkg.sv ====
// core_pkg
// shared types for the pipelined integer back end: opcodes,
// issued instruction and stage control structs, forwarding codes

`default_nettype none

package core_pkg;

	// register file addressing
	localparam int REG_ADDR_W = 5;
	localparam logic [REG_ADDR_W-1:0] ZERO_REG = 5'd31;

	// immediate field width, zero extended at execute
	localparam int IMM_W = 12;

	// width of the result field carried down the pipe
	localparam int WB_DATA_W = 64;

	typedef enum logic [3:0] {
		op_nop  = 4'd0,
		op_add  = 4'd1,
		op_sub  = 4'd2,
		op_and  = 4'd3,
		op_orr  = 4'd4,
		op_eor  = 4'd5,
		op_addi = 4'd6,
		op_subi = 4'd7,
		op_andi = 4'd8
	} opcode_e;

	// operand source select, 11 is never produced
	typedef enum logic [1:0] {
		fwd_none   = 2'b00,
		fwd_mem_wb = 2'b01,
		fwd_ex_mem = 2'b10
	} fwd_sel_e;

	// bit 1 enables the rn check, bit 0 adds the rm check
	typedef enum logic [1:0] {
		fwd_off     = 2'b00,
		fwd_rn_only = 2'b10,
		fwd_rn_rm   = 2'b11
	} fwd_en_e;

	typedef struct packed {
		opcode_e               op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rn;
		logic [REG_ADDR_W-1:0] rm;
		logic [IMM_W-1:0]      imm;
	} inst_t;

	typedef struct packed {
		logic    reg_write;
		logic    use_imm;
		opcode_e alu_op;
		fwd_en_e fwd_en;
	} ctrl_t;

	// result of a stage on its way to writeback
	typedef struct packed {
		logic                  reg_write;
		logic [REG_ADDR_W-1:0] rd;
		logic [WB_DATA_W-1:0]  data;
	} wb_t;

endpackage

`default_nettype wire

// ==== source/inst_decode.sv ====
// inst_decode
// maps an issued instruction to its stage control: alu operation,
// immediate use, forwarding enable and register write

`default_nettype none

module inst_decode (
	input  core_pkg::inst_t inst,
	output core_pkg::ctrl_t ctrl
);

	import core_pkg::*;

	logic is_reg_op;
	logic is_imm_op;

	// classify the opcode into register and immediate forms
	always_comb begin
		is_reg_op = 1'b0;
		is_imm_op = 1'b0;
		case (inst.op)
			op_add, op_sub, op_and, op_orr, op_eor: begin
				is_reg_op = 1'b1;
			end
			op_addi, op_subi, op_andi: begin
				is_imm_op = 1'b1;
			end
			default: begin
				is_reg_op = 1'b0;
				is_imm_op = 1'b0;
			end
		endcase
	end

	always_comb begin
		ctrl.alu_op  = inst.op;
		ctrl.use_imm = is_imm_op;

		// X31 is never written, so later stages can trust reg_write
		ctrl.reg_write = (is_reg_op || is_imm_op) && (inst.rd != ZERO_REG);

		// r-type checks both sources, i-type only rn
		if (is_reg_op) begin
			ctrl.fwd_en = fwd_rn_rm;
		end else if (is_imm_op) begin
			ctrl.fwd_en = fwd_rn_only;
		end else begin
			ctrl.fwd_en = fwd_off;
		end
	end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
// reg_file
// 31 general registers of DATA_W bits plus the X31 zero register,
// two combinational read ports and a write port that bypasses
// to the reads in the same cycle

`default_nettype none

module reg_file #(
	parameter int DATA_W = 64
) (
	input  wire logic                            clk,
	input  wire logic                            rst_n,
	input  wire logic [core_pkg::REG_ADDR_W-1:0] ra_addr,
	input  wire logic [core_pkg::REG_ADDR_W-1:0] rb_addr,
	output logic      [DATA_W-1:0]               ra_data,
	output logic      [DATA_W-1:0]               rb_data,
	input  wire logic                            we,
	input  wire logic [core_pkg::REG_ADDR_W-1:0] wa_addr,
	input  wire logic [DATA_W-1:0]               wd
);

	import core_pkg::*;

	localparam int NUM_REGS = 31;

	logic [DATA_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa_addr != ZERO_REG)) begin
			regs[wa_addr] <= wd;
		end
	end

	// X31 reads zero, a matching write wins over the stored value
	always_comb begin
		if (ra_addr == ZERO_REG) begin
			ra_data = '0;
		end else if (we && (wa_addr == ra_addr)) begin
			ra_data = wd;
		end else begin
			ra_data = regs[ra_addr];
		end

		if (rb_addr == ZERO_REG) begin
			rb_data = '0;
		end else if (we && (wa_addr == rb_addr)) begin
			rb_data = wd;
		end else begin
			rb_data = regs[rb_addr];
		end
	end

	// decode already drops writes to X31, none should reach here
	a_no_zero_write: assert property (@(posedge clk) disable iff (!rst_n)
		we |-> (wa_addr != ZERO_REG))
		else $error("reg_file: write to X31 reached the register file");

endmodule

`default_nettype wire

// ==== source/forwarding.sv ====
// forwarding
// detects write-use hazards between the instruction in execute and
// the two older instructions in EX/MEM and MEM/WB, and picks the
// source of operands A and B

`default_nettype none

module forwarding (
	input  core_pkg::fwd_en_e                    fwd_en,
	input  wire logic [core_pkg::REG_ADDR_W-1:0] rn,
	input  wire logic [core_pkg::REG_ADDR_W-1:0] rm,
	input  wire logic                            mem_reg_write,
	input  wire logic                            wb_reg_write,
	input  wire logic [core_pkg::REG_ADDR_W-1:0] mem_rd,
	input  wire logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
	output core_pkg::fwd_sel_e                   fwd_a,
	output core_pkg::fwd_sel_e                   fwd_b
);

	import core_pkg::*;

	// EX/MEM holds the younger result, so it is checked first
	function automatic fwd_sel_e pick_src(
		input logic [REG_ADDR_W-1:0] src,
		input logic                  mem_we,
		input logic [REG_ADDR_W-1:0] mem_dst,
		input logic                  wb_we,
		input logic [REG_ADDR_W-1:0] wb_dst
	);
		fwd_sel_e sel;
		sel = fwd_none;
		if (mem_we && (mem_dst != ZERO_REG) && (mem_dst == src)) begin
			sel = fwd_ex_mem;
		end else if (wb_we && (wb_dst != ZERO_REG) && (wb_dst == src)) begin
			sel = fwd_mem_wb;
		end
		return sel;
	endfunction

	always_comb begin
		fwd_a = fwd_none;
		fwd_b = fwd_none;

		// rn is checked for both instruction forms
		if (fwd_en[1]) begin
			fwd_a = pick_src(rn, mem_reg_write, mem_rd, wb_reg_write, wb_rd);
		end

		// rm only carries a source for r-type
		if (fwd_en[0]) begin
			fwd_b = pick_src(rm, mem_reg_write, mem_rd, wb_reg_write, wb_rd);
		end

		// an i-type rm field is not a register and must never steer operand B
		if (fwd_en != fwd_rn_rm) begin
			a_fwd_b_rtype_only: assert (fwd_b == fwd_none)
				else $error("forwarding: operand B forwarded without rm check");
		end
	end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
// alu
// 64-bit integer unit for the register and immediate opcodes
// add and subtract wrap around, no flags are produced

`default_nettype none

module alu #(
	parameter int DATA_W = 64
) (
	input  core_pkg::opcode_e        op,
	input  wire logic [DATA_W-1:0]   a,
	input  wire logic [DATA_W-1:0]   b,
	output logic      [DATA_W-1:0]   y
);

	import core_pkg::*;

	logic [DATA_W-1:0] sum;
	logic [DATA_W-1:0] diff;

	// both arithmetic results are formed, the opcode picks one
	assign sum  = a + b;
	assign diff = a - b;

	always_comb begin
		case (op)
			op_add, op_addi: begin
				y = sum;
			end
			op_sub, op_subi: begin
				y = diff;
			end
			op_and, op_andi: begin
				y = a & b;
			end
			op_orr: begin
				y = a | b;
			end
			op_eor: begin
				y = a ^ b;
			end
			// nop carries no write, result is don't care
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/int_pipe.sv ====
// int_pipe
// top of the integer back end: decode and register read, execute,
// a pass-through memory stage and writeback, with operand forwarding
// from EX/MEM and MEM/WB into execute

`default_nettype none

module int_pipe #(
	parameter int DATA_W = 64
) (
	input  wire logic                            clk,
	input  wire logic                            rst_n,
	input  wire logic                            issue,
	input  core_pkg::inst_t                      inst,
	output logic                                 wb_valid,
	output logic      [core_pkg::REG_ADDR_W-1:0] wb_reg,
	output logic      [DATA_W-1:0]               wb_data
);

	import core_pkg::*;

	// decode stage
	ctrl_t             dec_ctrl;
	ctrl_t             id_ctrl;
	logic [DATA_W-1:0] rf_a;
	logic [DATA_W-1:0] rf_b;

	// ID/EX register
	ctrl_t             id_ex_ctrl;
	inst_t             id_ex_inst;
	logic [DATA_W-1:0] id_ex_a;
	logic [DATA_W-1:0] id_ex_b;

	// execute stage
	fwd_sel_e          fwd_a;
	fwd_sel_e          fwd_b;
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] rm_val;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] alu_y;

	// EX/MEM and MEM/WB registers
	wb_t ex_mem;
	wb_t mem_wb;

	inst_decode u_decode (
		.inst (inst),
		.ctrl (dec_ctrl)
	);

	// an idle cycle enters the pipe as a bubble
	assign id_ctrl = issue ? dec_ctrl : '0;

	reg_file #(
		.DATA_W (DATA_W)
	) u_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_addr (inst.rn),
		.rb_addr (inst.rm),
		.ra_data (rf_a),
		.rb_data (rf_b),
		.we      (mem_wb.reg_write),
		.wa_addr (mem_wb.rd),
		.wd      (mem_wb.data)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex_ctrl <= '0;
		end else begin
			id_ex_ctrl <= id_ctrl;
			id_ex_inst <= inst;
			id_ex_a    <= rf_a;
			id_ex_b    <= rf_b;
		end
	end

	forwarding u_forwarding (
		.fwd_en        (id_ex_ctrl.fwd_en),
		.rn            (id_ex_inst.rn),
		.rm            (id_ex_inst.rm),
		.mem_reg_write (ex_mem.reg_write),
		.wb_reg_write  (mem_wb.reg_write),
		.mem_rd        (ex_mem.rd),
		.wb_rd         (mem_wb.rd),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b)
	);

	// operand muxes, EX/MEM has the younger value
	always_comb begin
		case (fwd_a)
			fwd_ex_mem: op_a = ex_mem.data;
			fwd_mem_wb: op_a = mem_wb.data;
			default:    op_a = id_ex_a;
		endcase

		case (fwd_b)
			fwd_ex_mem: rm_val = ex_mem.data;
			fwd_mem_wb: rm_val = mem_wb.data;
			default:    rm_val = id_ex_b;
		endcase

		// immediate is zero extended
		op_b = id_ex_ctrl.use_imm ? DATA_W'(id_ex_inst.imm) : rm_val;
	end

	alu #(
		.DATA_W (DATA_W)
	) u_alu (
		.op (id_ex_ctrl.alu_op),
		.a  (op_a),
		.b  (op_b),
		.y  (alu_y)
	);

	// no memory access, MEM/WB takes EX/MEM unchanged
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.reg_write <= 1'b0;
			mem_wb.reg_write <= 1'b0;
		end else begin
			ex_mem.reg_write <= id_ex_ctrl.reg_write;
			ex_mem.rd        <= id_ex_inst.rd;
			ex_mem.data      <= alu_y;
			mem_wb           <= ex_mem;
		end
	end

	assign wb_valid = mem_wb.reg_write;
	assign wb_reg   = mem_wb.rd;
	assign wb_data  = mem_wb.data;

	// wb_t data field is fixed in the package
	a_data_w: assert property (@(posedge clk) DATA_W == WB_DATA_W)
		else $error("int_pipe: DATA_W does not match the result field width");

	// zero register suppression in decode must hold all the way to writeback
	a_no_zero_wb: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> (wb_reg != ZERO_REG))
		else $error("int_pipe: writeback to X31");

endmodule

`default_nettype wire

// ==== sim/int_pipe_tb.sv ====
// int_pipe_tb
// testbench for the integer back end: reads golden vectors, issues
// the instruction stream and checks every writeback in order

`default_nettype none

module int_pipe_tb;

	import core_pkg::*;

	localparam int          DATA_W       = 64;
	localparam int          RESET_CYCLES = 5;
	localparam int          DRAIN_CYCLES = 6;
	localparam int          MARGIN       = 20;
	localparam logic [31:0] SEED         = 32'h8a48a6f9;
	localparam string       GOLDEN_FILE  = "sim/int_pipe_golden.txt";

	// one expected writeback
	typedef struct packed {
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0]     data;
	} wb_exp_t;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  issue;
	inst_t                 inst;
	logic                  wb_valid;
	logic [REG_ADDR_W-1:0] wb_reg;
	logic [DATA_W-1:0]     wb_data;

	inst_t   vec_inst[$];
	int      vec_idle[$];
	bit      vec_rand[$];
	wb_exp_t exp_q[$];

	int cycle_count = 0;
	int cycle_limit;

	always #20 clk = ~clk;

	int_pipe #(
		.DATA_W (DATA_W)
	) u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.issue    (issue),
		.inst     (inst),
		.wb_valid (wb_valid),
		.wb_reg   (wb_reg),
		.wb_data  (wb_data)
	);

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(
		input string             name,
		input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] expected
	);
		if (got !== expected) begin
			fail_run($sformatf("error at time %0t: %s is %h, expected %h",
				$time, name, got, expected));
		end
	endtask

	task automatic load_vectors();
		int                    fd;
		int                    idle;
		int                    rnd;
		int                    total;
		logic [8*200-1:0]      line;
		logic [8*8-1:0]        op_name;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rn;
		logic [REG_ADDR_W-1:0] rm;
		logic [11:0]           imm;
		logic [DATA_W-1:0]     value;
		inst_t                 vi;
		wb_exp_t               e;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			fail_run("could not open the golden vector file");
		end
		total = 0;
		line = '0;
		while ($fgets(line, fd) > 0) begin
			// comment and blank lines do not parse as vectors
			if ($sscanf(line, "%d %s %d %d %d %h %h %d",
					idle, op_name, rd, rn, rm, imm, value, rnd) == 8) begin
				case (op_name)
					64'("nop"):  vi.op = op_nop;
					64'("add"):  vi.op = op_add;
					64'("sub"):  vi.op = op_sub;
					64'("and"):  vi.op = op_and;
					64'("orr"):  vi.op = op_orr;
					64'("eor"):  vi.op = op_eor;
					64'("addi"): vi.op = op_addi;
					64'("subi"): vi.op = op_subi;
					64'("andi"): vi.op = op_andi;
					default: fail_run($sformatf("unknown opcode %0s in golden file", op_name));
				endcase
				vi.rd  = rd;
				vi.rn  = rn;
				vi.rm  = rm;
				vi.imm = imm;
				vec_inst.push_back(vi);
				vec_idle.push_back(idle);
				vec_rand.push_back(rnd != 0);
				// nop and X31 targets leave no writeback
				if ((vi.op != op_nop) && (rd != ZERO_REG)) begin
					e.rd   = rd;
					e.data = value;
					exp_q.push_back(e);
				end
				total += idle + 1 + ((rnd != 0) ? 1 : 0);
			end
			line = '0;
		end
		$fclose(fd);
		if (vec_inst.size() == 0) begin
			fail_run("golden vector file holds no vectors");
		end
		cycle_limit = RESET_CYCLES + total + 1 + DRAIN_CYCLES + MARGIN;
	endtask

	// outputs settle after the rising edge, sample in the low phase
	always @(negedge clk) begin : wb_check
		wb_exp_t item;
		if (rst_n && wb_valid) begin
			if (exp_q.size() == 0) begin
				fail_run("writeback seen while no result was expected");
			end else begin
				item = exp_q.pop_front();
				check_value("wb_reg", DATA_W'(wb_reg), DATA_W'(item.rd));
				check_value("wb_data", wb_data, item.data);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			fail_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
		end
	end

	initial begin : stimulus
		int extra;
		rst_n <= 1'b0;
		issue <= 1'b0;
		inst  <= '0;
		void'($urandom(SEED));
		load_vectors();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		foreach (vec_inst[i]) begin
			extra = vec_rand[i] ? int'($urandom % 2) : 0;
			repeat (vec_idle[i] + extra) begin
				@(posedge clk);
				issue <= 1'b0;
				inst  <= '0;
			end
			@(posedge clk);
			issue <= 1'b1;
			inst  <= vec_inst[i];
		end
		@(posedge clk);
		issue <= 1'b0;
		inst  <= '0;
		// last result leaves MEM/WB four edges after its issue
		repeat (DRAIN_CYCLES) @(posedge clk);
		if (exp_q.size() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			fail_run($sformatf("%0d expected writebacks never appeared", exp_q.size()));
		end
	end

endmodule

`default_nettype wire

// ==== sim/int_pipe_golden.txt ====
# idle op rd rn rm imm expected rand
# idle cycles before issue, registers in decimal, imm and expected in hex, rand 1 adds 0-1 idle
# reads of unwritten registers, wraparound and zero-extended immediates
2 addi 1 20 0 0ff 00000000000000ff 0
0 addi 2 31 0 fff 0000000000000fff 0
0 orr 3 21 22 000 0000000000000000 0
3 addi 4 30 0 123 0000000000000123 0
3 subi 5 30 0 001 ffffffffffffffff 0
3 sub 6 1 2 000 fffffffffffff100 0
3 andi 7 5 0 a5a 0000000000000a5a 0
3 eor 8 1 2 000 0000000000000f00 0
3 and 9 5 4 000 0000000000000123 0
# back to back on rn and rm
3 addi 10 31 0 010 0000000000000010 0
0 add 11 10 1 000 000000000000010f 0
0 sub 12 4 11 000 0000000000000014 0
0 orr 13 12 12 000 0000000000000014 0
0 addi 13 13 0 100 0000000000000114 0
# distance 2 and 3
3 addi 14 31 0 007 0000000000000007 0
0 addi 15 31 0 008 0000000000000008 0
0 add 16 14 31 000 0000000000000007 0
0 eor 17 14 15 000 000000000000000f 0
# youngest value wins
3 addi 18 31 0 001 0000000000000001 0
0 addi 18 31 0 002 0000000000000002 0
0 add 19 18 18 000 0000000000000004 0
3 addi 20 31 0 003 0000000000000003 0
0 addi 20 31 0 005 0000000000000005 0
0 addi 21 31 0 000 0000000000000000 0
0 orr 22 20 21 000 0000000000000005 0
# i-type with rm matching a pending rd
3 addi 23 31 0 0aa 00000000000000aa 0
0 andi 24 1 23 0f0 00000000000000f0 0
0 subi 25 23 23 00a 00000000000000a0 0
# X31 targets and nop
3 addi 31 31 0 777 0000000000000000 0
0 add 26 31 31 000 0000000000000000 0
0 orr 31 1 2 000 0000000000000000 0
0 addi 27 31 0 001 0000000000000001 0
0 nop 28 1 2 000 0000000000000000 0
0 add 29 28 31 000 0000000000000000 0
# random spacing
0 eor 30 27 26 000 0000000000000001 1
0 add 30 30 13 000 0000000000000115 1
0 sub 1 30 9 000 fffffffffffffff2 1
0 addi 2 1 0 00e 0000000000000000 0

// ==== filelist.f ====
source/core_pkg.sv
source/inst_decode.sv
source/reg_file.sv
source/forwarding.sv
source/alu.sv
source/int_pipe.sv
sim/int_pipe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the int_pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log
rm -f "$sim_log"

verilator --binary --assert -f filelist.f --top-module int_pipe_tb \
	-o int_pipe_sim > "$build_log" 2>&1 \
	&& ./obj_dir/int_pipe_sim > "$sim_log" 2>&1 \
	|| echo "build or simulation stopped with an error"

cat "$build_log" "$sim_log" 2>/dev/null
grep -q "ALL TESTS PASSED" "$sim_log" && echo "result: pass" && exit 0 || { echo "result: fail"; exit 1; }
